// ==== build.f ====
+incdir+.
cpu_types_pkg.sv
prf_pkg.sv
regfile_ram.sv
live_value_table.sv
regfile_mw_nr.sv
prf_top.sv
tb_prf_top.sv

// ==== cpu_types_pkg.sv ====
`include "prf_defs.svh"

// ============================================================
// Core-wide data types
// ============================================================

package cpu_types_pkg;

	// One operand value as it moves through the execution pipeline
	typedef logic [`PRF_VALUE_W-1:0] value_t;

	// Physical register number handed out by the rename stage
	// Its width follows the register count
	typedef logic [$clog2(`PRF_PREGS)-1:0] pregno_t;

endpackage

// ==== live_value_table.sv ====
`timescale 1ns/10ps
`include "prf_defs.svh"

// Live value table
// Tracks which write port holds the current copy of every register and
// looks up that port once per read port
module live_value_table (
	input logic clk,
	input logic rst,
	input logic [`PRF_WPORTS-1:0] wr,
	input cpu_types_pkg::pregno_t [`PRF_WPORTS-1:0] wa,
	input cpu_types_pkg::pregno_t [`PRF_RPORTS-1:0] ra,
	output prf_pkg::wport_t [`PRF_RPORTS-1:0] sel
);

	// One port index per physical register
	prf_pkg::wport_t lvt_q [`PRF_PREGS];

	// ============================================================
	// Table update
	// ============================================================

	// After reset every register is taken to live in the port 0 banks
	// Ports are scanned in rising order, so when several ports write the
	// same register in one cycle the last assignment, the highest port,
	// is the one that lands
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int n = 0; n < `PRF_PREGS; n++) begin
				lvt_q[n] <= '0;
			end
		end else begin
			for (int w = 0; w < `PRF_WPORTS; w++) begin
				if (wr[w]) begin
					lvt_q[wa[w]] <= prf_pkg::wport_t'(w);
				end
			end
		end
	end

	// ============================================================
	// Lookup per read port
	// ============================================================

	// The select is registered so it lines up with the bank read data,
	// which also appears one cycle after the address
	// It sees the table from before this edge's writes
	// Writes of the same edge are covered by forwarding one level up
	always_ff @(posedge clk) begin
		if (rst) begin
			sel <= '0;
		end else begin
			for (int r = 0; r < `PRF_RPORTS; r++) begin
				sel[r] <= lvt_q[ra[r]];
			end
		end
	end

	// A write strobe with an unknown address would leave the table
	// pointing at the wrong bank for whatever register it really meant
	for (genvar w = 0; w < `PRF_WPORTS; w++) begin : g_wa_chk
		a_wa_known : assert property (
			@(posedge clk) disable iff (rst) wr[w] |-> !$isunknown(wa[w])
		) else begin
			$error("live_value_table: port %0d writes an unknown address", w);
		end
	end

endmodule

// ==== prf_defs.svh ====
`ifndef PRF_DEFS_SVH
`define PRF_DEFS_SVH

// ============================================================
// Register file geometry
// ============================================================

// Number of write ports, one per writeback lane of the core
`define PRF_WPORTS 4

// Number of read ports, one per operand fetch lane
`define PRF_RPORTS 4

// Number of physical registers behind the rename map
`define PRF_PREGS 64

// Width of an operand value and of the flags tag stored beside it
`define PRF_VALUE_W 64
`define PRF_FLAGS_W 8

`endif

// ==== prf_pkg.sv ====
`include "prf_defs.svh"

// ============================================================
// Register file organisation types
// ============================================================

package prf_pkg;

	// Flags tag written together with each value
	typedef logic [`PRF_FLAGS_W-1:0] flags_t;

	// One RAM word of a bank
	// The tag sits in the upper bits and the value in the lower bits
	typedef struct packed {
		flags_t flags;
		cpu_types_pkg::value_t value;
	} prf_entry_t;

	// Index of a write port
	// The live value table keeps one of these for every register
	typedef logic [$clog2(`PRF_WPORTS)-1:0] wport_t;

endpackage

// ==== prf_top.sv ====
`timescale 1ns/10ps
`include "prf_defs.svh"

// Physical register file as seen by the rest of the core
// Write ports come from the writeback lanes, read ports feed the
// operand fetch stage
// There is no flow control, every port is accepted every cycle
module prf_top (
	input logic clk,
	input logic rst,
	input logic [`PRF_WPORTS-1:0] wr,
	input cpu_types_pkg::pregno_t [`PRF_WPORTS-1:0] wa,
	input cpu_types_pkg::value_t [`PRF_WPORTS-1:0] i,
	input prf_pkg::flags_t [`PRF_WPORTS-1:0] ti,
	input cpu_types_pkg::pregno_t [`PRF_RPORTS-1:0] ra,
	output cpu_types_pkg::value_t [`PRF_RPORTS-1:0] o,
	output prf_pkg::flags_t [`PRF_RPORTS-1:0] to
);

	// Wires between the port list and the register file core
	cpu_types_pkg::value_t [`PRF_RPORTS-1:0] rf_o;
	prf_pkg::flags_t [`PRF_RPORTS-1:0] rf_to;

	regfile_mw_nr regfile_inst (
		.clk(clk),
		.rst(rst),
		.wr(wr),
		.wa(wa),
		.i(i),
		.ti(ti),
		.ra(ra),
		.o(rf_o),
		.to(rf_to)
	);

	assign o = rf_o;
	assign to = rf_to;

	// ============================================================
	// End-to-end checks
	// ============================================================

	// The highest write port always wins a register, so whenever it writes
	// the address a read port presents in that same cycle, the read must
	// return exactly that port's entry one cycle later
	// This exercises forwarding and the one-cycle read latency together
	for (genvar r = 0; r < `PRF_RPORTS; r++) begin : g_fwd_chk
		a_top_port_fwd : assert property (
			@(posedge clk) disable iff (rst)
			(wr[`PRF_WPORTS-1] && wa[`PRF_WPORTS-1] == ra[r])
			|=> (o[r] == $past(i[`PRF_WPORTS-1]) && to[r] == $past(ti[`PRF_WPORTS-1]))
		) else begin
			$error("prf_top: read port %0d missed a same-cycle write", r);
		end
	end

	// A read port never returns unknown data for an address that was
	// written in the same cycle by any port
	for (genvar r = 0; r < `PRF_RPORTS; r++) begin : g_known_chk
		a_fwd_known : assert property (
			@(posedge clk) disable iff (rst)
			(!$isunknown(ra[r]) && ((wr[0] && wa[0] == ra[r])
				|| (wr[1] && wa[1] == ra[r]) || (wr[2] && wa[2] == ra[r])
				|| (wr[3] && wa[3] == ra[r])))
			|=> !$isunknown({o[r], to[r]})
		) else begin
			$error("prf_top: read port %0d returned unknown forwarded data", r);
		end
	end

endmodule

// ==== regfile_mw_nr.sv ====
`timescale 1ns/10ps
`include "prf_defs.svh"

// Multi-write multi-read register file
// Every write port owns one bank per read port, so each bank only ever
// sees one writer and one reader
// The live value table tells each read port which write port's bank
// holds the current copy, and a small forwarding path covers writes that
// land in the same cycle as the read address
module regfile_mw_nr (
	input logic clk,
	input logic rst,
	input logic [`PRF_WPORTS-1:0] wr,
	input cpu_types_pkg::pregno_t [`PRF_WPORTS-1:0] wa,
	input cpu_types_pkg::value_t [`PRF_WPORTS-1:0] i,
	input prf_pkg::flags_t [`PRF_WPORTS-1:0] ti,
	input cpu_types_pkg::pregno_t [`PRF_RPORTS-1:0] ra,
	output cpu_types_pkg::value_t [`PRF_RPORTS-1:0] o,
	output prf_pkg::flags_t [`PRF_RPORTS-1:0] to
);

	// Incoming entries, value and tag joined into one RAM word
	prf_pkg::prf_entry_t wr_entry [`PRF_WPORTS];

	// Read data of every bank, first index is the write port
	prf_pkg::prf_entry_t bank_rdata [`PRF_WPORTS][`PRF_RPORTS];

	// Registered bank select from the live value table
	prf_pkg::wport_t [`PRF_RPORTS-1:0] lvt_sel;

	// Forwarding match in the cycle of the address
	logic [`PRF_RPORTS-1:0] fwd_hit_d;
	prf_pkg::wport_t fwd_port_d [`PRF_RPORTS];

	// Forwarding state, one cycle later and aligned with the bank data
	logic [`PRF_RPORTS-1:0] fwd_hit_q;
	prf_pkg::wport_t fwd_port_q [`PRF_RPORTS];
	prf_pkg::prf_entry_t wr_entry_q [`PRF_WPORTS];

	// Entry finally chosen for each read port
	prf_pkg::prf_entry_t rd_entry [`PRF_RPORTS];

	always_comb begin
		for (int w = 0; w < `PRF_WPORTS; w++) begin
			wr_entry[w].flags = ti[w];
			wr_entry[w].value = i[w];
		end
	end

	// ============================================================
	// Bank array
	// ============================================================

	// Bank [w][r] is written only by port w and read only by port r
	// All banks of one write port hold identical contents
	for (genvar w = 0; w < `PRF_WPORTS; w++) begin : g_wport
		for (genvar r = 0; r < `PRF_RPORTS; r++) begin : g_rport
			regfile_ram ram_inst (
				.clk(clk),
				.we(wr[w]),
				.waddr(wa[w]),
				.wdata(wr_entry[w]),
				.raddr(ra[r]),
				.rdata(bank_rdata[w][r])
			);
		end
	end

	live_value_table lvt_inst (
		.clk(clk),
		.rst(rst),
		.wr(wr),
		.wa(wa),
		.ra(ra),
		.sel(lvt_sel)
	);

	// ============================================================
	// Same-cycle forwarding
	// ============================================================

	// The banks read before they write and the table lookup sees the old
	// table, so a write on the same edge as the read address would be
	// missed without this path
	// Scanning ports upward leaves the highest matching port, in line with
	// the table update rule
	always_comb begin
		for (int r = 0; r < `PRF_RPORTS; r++) begin
			fwd_hit_d[r] = 1'b0;
			fwd_port_d[r] = '0;
			for (int w = 0; w < `PRF_WPORTS; w++) begin
				if (wr[w] && wa[w] == ra[r]) begin
					fwd_hit_d[r] = 1'b1;
					fwd_port_d[r] = prf_pkg::wport_t'(w);
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			fwd_hit_q <= '0;
			for (int r = 0; r < `PRF_RPORTS; r++) begin
				fwd_port_q[r] <= '0;
			end
		end else begin
			fwd_hit_q <= fwd_hit_d;
			for (int r = 0; r < `PRF_RPORTS; r++) begin
				fwd_port_q[r] <= fwd_port_d[r];
			end
		end
	end

	// Held copy of each port's write data
	// Only looked at when the matching hit flag is set
	always_ff @(posedge clk) begin
		for (int w = 0; w < `PRF_WPORTS; w++) begin
			wr_entry_q[w] <= wr_entry[w];
		end
	end

	// ============================================================
	// Output selection
	// ============================================================

	// A forwarding hit overrides the table select
	always_comb begin
		for (int r = 0; r < `PRF_RPORTS; r++) begin
			if (fwd_hit_q[r]) begin
				rd_entry[r] = wr_entry_q[fwd_port_q[r]];
			end else begin
				rd_entry[r] = bank_rdata[lvt_sel[r]][r];
			end
			o[r] = rd_entry[r].value;
			to[r] = rd_entry[r].flags;
		end
	end

	// An unknown select after reset means the table took an unknown write
	// or read address somewhere upstream
	a_sel_known : assert property (
		@(posedge clk) disable iff (rst) !$isunknown(lvt_sel)
	) else begin
		$error("regfile_mw_nr: live value table select is unknown");
	end

endmodule

// ==== regfile_ram.sv ====
`timescale 1ns/10ps
`include "prf_defs.svh"

// Single bank of the register file
// One write port and one read port, both on the rising edge of clk
module regfile_ram (
	input logic clk,
	input logic we,
	input cpu_types_pkg::pregno_t waddr,
	input prf_pkg::prf_entry_t wdata,
	input cpu_types_pkg::pregno_t raddr,
	output prf_pkg::prf_entry_t rdata
);

	// Storage array, one entry per physical register
	// Contents are undefined until a register is first written
	prf_pkg::prf_entry_t mem [`PRF_PREGS];

	// Write and read share one edge
	// The nonblocking read picks up the word as it was before this edge,
	// so a read that hits a write in the same cycle returns the old data
	always_ff @(posedge clk) begin
		if (we) begin
			mem[waddr] <= wdata;
		end
		rdata <= mem[raddr];
	end

	// ============================================================
	// Checks
	// ============================================================

	// An unknown write address would corrupt an arbitrary set of entries
	// in simulation and hide the real fault until much later
	a_waddr_known : assert property (
		@(posedge clk) we |-> !$isunknown(waddr)
	) else begin
		$error("regfile_ram: write enabled with unknown address");
	end

endmodule

// ==== tb_prf_top.sv ====
`timescale 1ns/10ps
`include "prf_defs.svh"

// Testbench for the physical register file
// A shadow copy of every register predicts each read, and assertions
// compare the read ports against that prediction one cycle later
module tb_prf_top;

	localparam int CLK_PERIOD = 8;
	localparam int RANDOM_CYCLES = 400;
	// Cycle count of all phases below, reset and tail included
	localparam int STIM_CYCLES = 2 + 2 * `PRF_PREGS + 3 * `PRF_WPORTS + 2 * 5 + 6 * 3
		+ RANDOM_CYCLES + 2;

	logic clk;
	logic rst;
	logic [`PRF_WPORTS-1:0] wr;
	cpu_types_pkg::pregno_t [`PRF_WPORTS-1:0] wa;
	cpu_types_pkg::value_t [`PRF_WPORTS-1:0] i;
	prf_pkg::flags_t [`PRF_WPORTS-1:0] ti;
	cpu_types_pkg::pregno_t [`PRF_RPORTS-1:0] ra;
	cpu_types_pkg::value_t [`PRF_RPORTS-1:0] o;
	prf_pkg::flags_t [`PRF_RPORTS-1:0] to;

	// Shadow register contents and whether each register was ever written
	prf_pkg::prf_entry_t shadow [`PRF_PREGS];
	logic shadow_valid [`PRF_PREGS];

	// Expectation in the cycle of the address, then held for the check edge
	cpu_types_pkg::value_t [`PRF_RPORTS-1:0] exp_value_d;
	prf_pkg::flags_t [`PRF_RPORTS-1:0] exp_flags_d;
	logic [`PRF_RPORTS-1:0] chk_d;
	logic [`PRF_RPORTS-1:0] fwd_d;
	cpu_types_pkg::value_t [`PRF_RPORTS-1:0] exp_value_q;
	prf_pkg::flags_t [`PRF_RPORTS-1:0] exp_flags_q;
	logic [`PRF_RPORTS-1:0] chk_q;
	logic [`PRF_RPORTS-1:0] fwd_q;

	int checks_total;
	int fwd_checks;
	logic [31:0] rng_state;

	prf_top prf_top_inst (
		.clk(clk),
		.rst(rst),
		.wr(wr),
		.wa(wa),
		.i(i),
		.ti(ti),
		.ra(ra),
		.o(o),
		.to(to)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// Watchdog sized from the cycle count plus a margin of 20 cycles
	initial begin
		#((STIM_CYCLES + 20) * CLK_PERIOD);
		$display("Watchdog: the run hung and did not finish in the allowed time");
		$display("=== FAIL ===");
		$fatal(1, "timeout");
	end

	// ============================================================
	// Model and helpers
	// ============================================================

	// xorshift32 step on the shared state
	function automatic logic [31:0] next_random();
		logic [31:0] s;
		s = rng_state;
		s ^= s << 13;
		s ^= s >> 17;
		s ^= s << 5;
		rng_state = s;
		return s;
	endfunction

	function automatic cpu_types_pkg::value_t random_value();
		return {next_random(), next_random()};
	endfunction

	task automatic clear_writes();
		wr = '0;
		wa = '0;
		i = '0;
		ti = '0;
	endtask

	// Applies this cycle's writes to the shadow copy in rising port order,
	// so the highest writing port ends up owning a shared register
	// The read expectation is taken after those writes
	task automatic model_cycle();
		for (int w = 0; w < `PRF_WPORTS; w++) begin
			if (wr[w]) begin
				shadow[wa[w]].flags = ti[w];
				shadow[wa[w]].value = i[w];
				shadow_valid[wa[w]] = 1'b1;
			end
		end
		for (int r = 0; r < `PRF_RPORTS; r++) begin
			exp_value_d[r] = shadow[ra[r]].value;
			exp_flags_d[r] = shadow[ra[r]].flags;
			chk_d[r] = shadow_valid[ra[r]];
			fwd_d[r] = 1'b0;
			for (int w = 0; w < `PRF_WPORTS; w++) begin
				if (wr[w] && wa[w] == ra[r]) begin
					fwd_d[r] = 1'b1;
				end
			end
		end
	endtask

	task automatic write_port(int w, int addr);
		wr[w] = 1'b1;
		wa[w] = cpu_types_pkg::pregno_t'(addr);
		i[w] = random_value();
		ti[w] = prf_pkg::flags_t'(next_random());
	endtask

	// Expectation moves to the check stage on the edge that samples ra
	always @(posedge clk) begin
		if (rst) begin
			chk_q <= '0;
			fwd_q <= '0;
		end else begin
			for (int r = 0; r < `PRF_RPORTS; r++) begin
				if (chk_q[r]) begin
					checks_total++;
					if (fwd_q[r]) begin
						fwd_checks++;
					end
				end
			end
			chk_q <= chk_d;
			fwd_q <= fwd_d;
			exp_value_q <= exp_value_d;
			exp_flags_q <= exp_flags_d;
		end
	end

	// One value check and one flags check per read port
	for (genvar r = 0; r < `PRF_RPORTS; r++) begin : g_read_chk
		a_value : assert property (
			@(posedge clk) disable iff (rst) chk_q[r] |-> o[r] == exp_value_q[r]
		) else begin
			$display("Error at %0t ns: o[%0d] expected %h, got %h", $time, r,
				$sampled(exp_value_q[r]), $sampled(o[r]));
			$display("=== FAIL ===");
			$fatal(1, "read port %0d returned a wrong value", r);
		end
		a_flags : assert property (
			@(posedge clk) disable iff (rst) chk_q[r] |-> to[r] == exp_flags_q[r]
		) else begin
			$display("Error at %0t ns: to[%0d] expected %h, got %h", $time, r,
				$sampled(exp_flags_q[r]), $sampled(to[r]));
			$display("=== FAIL ===");
			$fatal(1, "read port %0d returned wrong flags", r);
		end
	end

	// ============================================================
	// Stimulus phases
	// ============================================================

	// Every register through port 0, each read port following the write
	task automatic fill_registers();
		for (int n = 0; n < `PRF_PREGS; n++) begin
			@(negedge clk);
			clear_writes();
			write_port(0, n);
			for (int r = 0; r < `PRF_RPORTS; r++) begin
				ra[r] = cpu_types_pkg::pregno_t'(n);
			end
			model_cycle();
		end
	endtask

	// Each read port walks all registers from a different starting point
	task automatic read_all_registers();
		for (int n = 0; n < `PRF_PREGS; n++) begin
			@(negedge clk);
			clear_writes();
			for (int r = 0; r < `PRF_RPORTS; r++) begin
				ra[r] = cpu_types_pkg::pregno_t'((n + r * 16) % `PRF_PREGS);
			end
			model_cycle();
		end
	endtask

	// Write and read of one register in the same cycle, per write port
	task automatic check_forwarding();
		int k;
		for (int w = 0; w < `PRF_WPORTS; w++) begin
			k = next_random() % `PRF_PREGS;
			@(negedge clk);
			clear_writes();
			write_port(w, k);
			for (int r = 0; r < `PRF_RPORTS; r++) begin
				ra[r] = cpu_types_pkg::pregno_t'(k);
			end
			model_cycle();
			@(negedge clk);
			clear_writes();
			model_cycle();
			@(negedge clk);
			write_port(w, k);
			for (int r = 1; r < `PRF_RPORTS; r++) begin
				ra[r] = cpu_types_pkg::pregno_t'(next_random());
			end
			model_cycle();
		end
	endtask

	// All ports write distinct registers, then every read port reads
	// every port's register, which touches each of the sixteen banks
	task automatic check_bank_pairs();
		int k [`PRF_WPORTS];
		for (int rep = 0; rep < 2; rep++) begin
			@(negedge clk);
			clear_writes();
			for (int w = 0; w < `PRF_WPORTS; w++) begin
				k[w] = (rep * 8 + w * 13 + 5) % `PRF_PREGS;
				write_port(w, k[w]);
			end
			for (int r = 0; r < `PRF_RPORTS; r++) begin
				ra[r] = cpu_types_pkg::pregno_t'(k[r]);
			end
			model_cycle();
			for (int s = 0; s < `PRF_WPORTS; s++) begin
				@(negedge clk);
				clear_writes();
				for (int r = 0; r < `PRF_RPORTS; r++) begin
					ra[r] = cpu_types_pkg::pregno_t'(k[(r + s) % `PRF_WPORTS]);
				end
				model_cycle();
			end
		end
	endtask

	// Several ports on one register, read at once, next cycle and later
	task automatic check_same_register();
		logic [`PRF_WPORTS-1:0] masks [6];
		int k;
		masks = '{4'b1111, 4'b0101, 4'b1010, 4'b0111, 4'b0011, 4'b1100};
		for (int m = 0; m < 6; m++) begin
			k = next_random() % `PRF_PREGS;
			@(negedge clk);
			clear_writes();
			for (int w = 0; w < `PRF_WPORTS; w++) begin
				if (masks[m][w]) begin
					write_port(w, k);
				end
			end
			for (int r = 0; r < `PRF_RPORTS; r++) begin
				ra[r] = cpu_types_pkg::pregno_t'(k);
			end
			model_cycle();
			@(negedge clk);
			clear_writes();
			model_cycle();
			// Unrelated write between the two later reads
			@(negedge clk);
			write_port(0, (k + 1) % `PRF_PREGS);
			model_cycle();
		end
	endtask

	// Random traffic, often squeezed into eight registers so that ports
	// collide with each other and with the read addresses
	task automatic run_random();
		logic narrow;
		logic [31:0] x;
		for (int c = 0; c < RANDOM_CYCLES; c++) begin
			@(negedge clk);
			clear_writes();
			x = next_random();
			narrow = x[8];
			for (int w = 0; w < `PRF_WPORTS; w++) begin
				if (x[w]) begin
					write_port(w, narrow ? next_random() % 8 : next_random() % `PRF_PREGS);
				end
			end
			for (int r = 0; r < `PRF_RPORTS; r++) begin
				ra[r] = cpu_types_pkg::pregno_t'(narrow ? next_random() % 8 : next_random());
			end
			model_cycle();
		end
	endtask

	// ============================================================
	// Main sequence
	// ============================================================

	initial begin
		rng_state = 32'h28914662;
		checks_total = 0;
		fwd_checks = 0;
		rst = 1'b1;
		clear_writes();
		ra = '0;
		chk_d = '0;
		fwd_d = '0;
		exp_value_d = '0;
		exp_flags_d = '0;
		for (int n = 0; n < `PRF_PREGS; n++) begin
			shadow_valid[n] = 1'b0;
		end
		// Reset spans two rising edges, released on the falling edge after
		repeat (2) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;

		fill_registers();
		read_all_registers();
		check_forwarding();
		check_bank_pairs();
		check_same_register();
		run_random();

		// Let the last reads reach their check edge
		@(negedge clk);
		clear_writes();
		chk_d = '0;
		@(negedge clk);

		if (checks_total < 2 * `PRF_PREGS * `PRF_RPORTS || fwd_checks == 0) begin
			$display("Too few reads were checked, the stimulus missed some cases");
			$display("=== FAIL ===");
			$fatal(1, "checks %0d, forwarded %0d", checks_total, fwd_checks);
		end else begin
			$display("Checked %0d reads, %0d of them forwarded", checks_total, fwd_checks);
			$display("=== PASS ===");
			$finish;
		end
	end

endmodule
